/* Makefile */
# Verilator flow for the Cholesky factor unit

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_chol
RTL_TOP   ?= chol_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --timing --assert -Wno-fatal
RTL_SRCS  ?= $(shell grep '^design/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	-./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/chol_ctrl.sv */
`timescale 1ns/10ps

module chol_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  chol_fixed_pkg::tri_t     a,
    input  logic                     a_valid,
    output logic                     a_ready,
    output chol_fixed_pkg::tri_t     l,
    output logic                     l_valid,
    output chol_seq_pkg::mac_req_t   mac_req,
    output logic                     mac_en,
    input  chol_fixed_pkg::fx_t      mac_res,
    output logic                     sqrt_start,
    output chol_fixed_pkg::fx_t      sqrt_rad,
    input  logic                     sqrt_done,
    input  chol_fixed_pkg::fx_t      sqrt_root,
    output logic                     div_start,
    output chol_fixed_pkg::fx_t      div_num,
    output chol_fixed_pkg::fx_t      div_den,
    input  logic                     div_done,
    input  chol_fixed_pkg::fx_t      div_quot
);
    import chol_fixed_pkg::*;
    import chol_seq_pkg::*;

    chol_state_t      state_q;
    logic [CNT_W-1:0] cnt_q;      // Cycle within the residual phase
    logic [IDX_W-1:0] i_q;        // Row
    logic [IDX_W-1:0] j_q;        // Column
    tri_t             a_q;
    tri_t             l_q;

    logic             acc_phase;
    logic             res_ready;
    logic [CNT_W-1:0] k_prev;

    // Residual phase
    // --------------------
    // Cycle 0 loads A(i,j), cycles 1..j subtract L(i,k)*L(j,k)
    assign acc_phase = (state_q == DIAG_ACC) || (state_q == OFF_ACC);
    assign mac_en    = acc_phase && (cnt_q <= CNT_W'(j_q));
    assign res_ready = acc_phase && (cnt_q == CNT_W'(j_q) + 1'b1); // MAC output settled
    assign k_prev    = (cnt_q == '0) ? '0 : cnt_q - 1'b1;

    always_comb begin
        if (cnt_q == '0) begin
            mac_req.op = LOAD;
        end else begin
            mac_req.op = MSUB;
        end
        mac_req.a    = l_q[tri_idx(int'(i_q), int'(k_prev))];
        mac_req.b    = l_q[tri_idx(int'(j_q), int'(k_prev))];
        mac_req.load = a_q[tri_idx(int'(i_q), int'(j_q))];
    end

    assign sqrt_start = res_ready && (state_q == DIAG_ACC);
    assign sqrt_rad   = mac_res;
    assign div_start  = res_ready && (state_q == OFF_ACC);
    assign div_num    = mac_res;
    assign div_den    = l_q[tri_idx(int'(j_q), int'(j_q))]; // Column diagonal

    assign a_ready = (state_q == IDLE);
    assign l       = l_q;

    always_ff @(posedge clk) begin
        if (a_ready && a_valid) begin
            a_q <= a;
        end
    end

    // Column sequence
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            i_q     <= '0;
            j_q     <= '0;
            l_q     <= '0;
            l_valid <= 1'b0;
        end else begin
            l_valid <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (a_valid) begin
                        i_q     <= '0;
                        j_q     <= '0;
                        cnt_q   <= '0;
                        state_q <= DIAG_ACC;
                    end
                end
                DIAG_ACC, OFF_ACC: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (res_ready && state_q == DIAG_ACC) begin
                        state_q <= DIAG_SQRT;
                    end else if (res_ready) begin
                        state_q <= OFF_DIV;
                    end
                end
                DIAG_SQRT: begin
                    if (sqrt_done) begin
                        l_q[tri_idx(int'(j_q), int'(j_q))] <= sqrt_root;
                        cnt_q <= '0;
                        if (j_q == IDX_W'(MAT_N - 1)) begin
                            state_q <= DONE;
                            l_valid <= 1'b1;
                        end else begin
                            i_q     <= j_q + 1'b1;        // First row below the diagonal
                            state_q <= OFF_ACC;
                        end
                    end
                end
                OFF_DIV: begin
                    if (div_done) begin
                        l_q[tri_idx(int'(i_q), int'(j_q))] <= div_quot;
                        cnt_q <= '0;
                        if (i_q == IDX_W'(MAT_N - 1)) begin
                            j_q     <= j_q + 1'b1;        // Next column starts on its diagonal
                            i_q     <= j_q + 1'b1;
                            state_q <= DIAG_ACC;
                        end else begin
                            i_q     <= i_q + 1'b1;
                            state_q <= OFF_ACC;
                        end
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Result strobe is a single cycle and only while the sequence is finishing
    a_l_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        l_valid |-> (state_q == DONE) ##1 !l_valid);

endmodule

/* design/chol_fixed_pkg.sv */
package chol_fixed_pkg;

    // Number format
    // --------------------
    localparam int FX_W      = 32;
    localparam int FRAC_BITS = 16;                      // Q16.16
    localparam int EXT_W     = FX_W + FRAC_BITS;        // Operand shifted up by the fraction
    localparam int ROOT_W    = EXT_W / 2;               // Integer root of an EXT_W value

    // Matrix shape
    // --------------------
    localparam int MAT_N   = 5;
    localparam int TRI_LEN = MAT_N * (MAT_N + 1) / 2;   // Lower triangle with diagonal
    localparam int IDX_W   = $clog2(MAT_N);             // Row or column index

    typedef logic signed [FX_W-1:0]   fx_t;             // Signed Q16.16 element
    typedef logic signed [2*FX_W-1:0] acc_t;            // Signed Q32.32 sum of products

    // Row-major lower triangle, element (i,j) with i >= j
    typedef fx_t [TRI_LEN-1:0] tri_t;

    function automatic int tri_idx(input int row, input int col);
        return row * (row + 1) / 2 + col;
    endfunction

endpackage

/* design/chol_seq_pkg.sv */
package chol_seq_pkg;

    typedef enum logic [2:0] {
        IDLE,
        DIAG_ACC,     // Residual of a diagonal element
        DIAG_SQRT,
        OFF_ACC,      // Residual of an element below the diagonal
        OFF_DIV,
        DONE
    } chol_state_t;

    typedef enum logic {
        LOAD,         // acc = load << FRAC_BITS
        MSUB          // acc = acc - a * b
    } mac_op_t;

    typedef struct packed {
        mac_op_t             op;
        chol_fixed_pkg::fx_t a;
        chol_fixed_pkg::fx_t b;
        chol_fixed_pkg::fx_t load;
    } mac_req_t;

    localparam int SQRT_CYCLES = 24;   // One root bit per cycle
    localparam int DIV_CYCLES  = 48;   // One quotient bit per cycle
    localparam int CNT_W       = 6;

endpackage

/* design/chol_top.sv */
`timescale 1ns/10ps

module chol_top (
    input  logic                 clk,
    input  logic                 rst,
    input  chol_fixed_pkg::tri_t a,
    input  logic                 a_valid,
    output logic                 a_ready,
    output chol_fixed_pkg::tri_t l,
    output logic                 l_valid
);
    import chol_fixed_pkg::*;
    import chol_seq_pkg::*;

    mac_req_t mac_req;
    logic     mac_en;
    fx_t      mac_res;

    logic     sqrt_start;
    fx_t      sqrt_rad;
    logic     sqrt_done;
    fx_t      sqrt_root;

    logic     div_start;
    fx_t      div_num;
    fx_t      div_den;
    logic     div_done;
    fx_t      div_quot;

    chol_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .a          (a),
        .a_valid    (a_valid),
        .a_ready    (a_ready),
        .l          (l),
        .l_valid    (l_valid),
        .mac_req    (mac_req),
        .mac_en     (mac_en),
        .mac_res    (mac_res),
        .sqrt_start (sqrt_start),
        .sqrt_rad   (sqrt_rad),
        .sqrt_done  (sqrt_done),
        .sqrt_root  (sqrt_root),
        .div_start  (div_start),
        .div_num    (div_num),
        .div_den    (div_den),
        .div_done   (div_done),
        .div_quot   (div_quot)
    );

    // Shared arithmetic units
    // --------------------
    fx_mac u_mac (
        .clk (clk),
        .rst (rst),
        .req (mac_req),
        .en  (mac_en),
        .res (mac_res)
    );

    fx_sqrt u_sqrt (
        .clk   (clk),
        .rst   (rst),
        .start (sqrt_start),
        .rad   (sqrt_rad),
        .done  (sqrt_done),
        .root  (sqrt_root)
    );

    fx_div u_div (
        .clk   (clk),
        .rst   (rst),
        .start (div_start),
        .num   (div_num),
        .den   (div_den),
        .done  (div_done),
        .quot  (div_quot)
    );

endmodule

/* design/fx_div.sv */
`timescale 1ns/10ps

module fx_div (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  chol_fixed_pkg::fx_t num,
    input  chol_fixed_pkg::fx_t den,
    output logic                done,
    output chol_fixed_pkg::fx_t quot
);
    import chol_fixed_pkg::*;
    import chol_seq_pkg::*;

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic             neg;        // Sign of the result
    logic [EXT_W-1:0] q;          // Dividend out at the top, quotient in at the bottom
    logic [FX_W:0]    rem;
    logic [FX_W-1:0]  d;          // Divisor magnitude

    logic [FX_W-1:0]  num_mag;
    logic [FX_W-1:0]  den_mag;
    logic [FX_W:0]    rem_sh;
    logic             fits;
    logic [FX_W-1:0]  q_low;

    assign num_mag = num[FX_W-1] ? -num : num;
    assign den_mag = den[FX_W-1] ? -den : den;
    assign rem_sh  = {rem[FX_W-1:0], q[EXT_W-1]};
    assign fits    = (rem_sh >= {1'b0, d});

    // Control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(DIV_CYCLES - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Restoring division on magnitudes
    // --------------------
    always_ff @(posedge clk) begin
        if (start) begin
            q   <= {num_mag, {FRAC_BITS{1'b0}}};     // Keeps Q16.16 scaling of the quotient
            rem <= '0;
            d   <= den_mag;
            neg <= num[FX_W-1] ^ den[FX_W-1];
        end else if (busy) begin
            q   <= {q[EXT_W-2:0], fits};
            rem <= fits ? rem_sh - {1'b0, d} : rem_sh;
        end
    end

    // Sign applied last, so the result truncates toward zero
    assign q_low = q[FX_W-1:0];
    assign quot  = neg ? fx_t'(-q_low) : fx_t'(q_low);

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);
    a_den_nonzero:   assert property (@(posedge clk) disable iff (rst) start |-> den != '0);

endmodule

/* design/fx_mac.sv */
`timescale 1ns/10ps

module fx_mac (
    input  logic                   clk,
    input  logic                   rst,
    input  chol_seq_pkg::mac_req_t req,
    input  logic                   en,
    output chol_fixed_pkg::fx_t    res
);
    import chol_fixed_pkg::*;
    import chol_seq_pkg::*;

    acc_t acc;   // Q32.32

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (en) begin
            if (req.op == LOAD) begin
                acc <= acc_t'(req.load) <<< FRAC_BITS;   // Q16.16 up to Q32.32
            end else begin
                acc <= acc - acc_t'(req.a) * acc_t'(req.b);
            end
        end
    end

    // Back to Q16.16
    assign res = fx_t'(acc[EXT_W-1:FRAC_BITS]);

endmodule

/* design/fx_sqrt.sv */
`timescale 1ns/10ps

module fx_sqrt (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  chol_fixed_pkg::fx_t rad,
    output logic                done,
    output chol_fixed_pkg::fx_t root
);
    import chol_fixed_pkg::*;
    import chol_seq_pkg::*;

    logic              busy;
    logic [CNT_W-1:0]  cnt;
    logic [EXT_W-1:0]  x;         // Radicand pairs, MSB first
    logic [ROOT_W+1:0] rem;
    logic [ROOT_W-1:0] q;         // Partial root

    logic [ROOT_W+1:0] rem_sh;
    logic [ROOT_W+1:0] trial;
    logic              fits;

    assign rem_sh = {rem[ROOT_W-1:0], x[EXT_W-1 -: 2]};  // Bring down next pair
    assign trial  = {q, 2'b01};                          // 4q + 1
    assign fits   = (rem_sh >= trial);

    // Control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(SQRT_CYCLES - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Datapath
    // --------------------
    always_ff @(posedge clk) begin
        if (start) begin
            x   <= (rad > 0) ? {rad, {FRAC_BITS{1'b0}}} : '0;   // Non-positive gives 0
            rem <= '0;
            q   <= '0;
        end else if (busy) begin
            x <= x << 2;
            if (fits) begin
                rem <= rem_sh - trial;
                q   <= {q[ROOT_W-2:0], 1'b1};
            end else begin
                rem <= rem_sh;
                q   <= {q[ROOT_W-2:0], 1'b0};
            end
        end
    end

    assign root = fx_t'({{(FX_W - ROOT_W){1'b0}}, q});

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

/* project.f */
design/chol_fixed_pkg.sv
design/chol_seq_pkg.sv
design/fx_mac.sv
design/fx_sqrt.sv
design/fx_div.sv
design/chol_ctrl.sv
design/chol_top.sv
+incdir+testbench
testbench/tb_chol.sv

/* testbench/tb_chol_model.svh */
`ifndef TB_CHOL_MODEL_SVH
`define TB_CHOL_MODEL_SVH

// Position of element (row, col) in the row-major lower triangle
function automatic int tri_pos(input int row, input int col);
    return row * (row + 1) / 2 + col;
endfunction

// Floor of sqrt(r * 2^16) found by bisection over the root
function automatic fx_t model_sqrt(input fx_t r);
    longint target;
    longint lo;
    longint hi;
    longint mid;
    if (r <= 0) begin
        return '0;
    end
    target = longint'(r) <<< FRAC_BITS;
    lo     = 0;
    hi     = 64'd16777216;                 // 2^24, above any root of a 47-bit value
    while (hi - lo > 1) begin
        mid = (lo + hi) / 2;
        if (mid * mid <= target) begin
            lo = mid;
        end else begin
            hi = mid;
        end
    end
    return fx_t'(lo);
endfunction

// (num * 2^16) / den, truncated toward zero
function automatic fx_t model_div(input fx_t num, input fx_t den);
    longint q;
    q = (longint'(num) <<< FRAC_BITS) / longint'(den);
    return fx_t'(q);
endfunction

// A(i,j) minus sum over k<j of L(i,k)*L(j,k), taken in Q32.32
function automatic fx_t model_residual(input fx_t a_val, input tri_t l_cur,
                                       input int i, input int j);
    longint acc;
    int     k;
    acc = longint'(a_val) <<< FRAC_BITS;
    for (k = 0; k < j; k++) begin
        acc -= longint'(l_cur[tri_pos(i, k)]) * longint'(l_cur[tri_pos(j, k)]);
    end
    return fx_t'(acc >>> FRAC_BITS);       // Bits 47:16
endfunction

// Expected Cholesky factor, column by column
function automatic tri_t model_chol(input tri_t a_in);
    tri_t l_exp;
    fx_t  res;
    int   i;
    int   j;
    l_exp = '0;
    for (j = 0; j < MAT_N; j++) begin
        res = model_residual(a_in[tri_pos(j, j)], l_exp, j, j);
        l_exp[tri_pos(j, j)] = model_sqrt(res);
        for (i = j + 1; i < MAT_N; i++) begin
            res = model_residual(a_in[tri_pos(i, j)], l_exp, i, j);
            l_exp[tri_pos(i, j)] = model_div(res, l_exp[tri_pos(j, j)]);
        end
    end
    return l_exp;
endfunction

`endif

/* testbench/tb_chol.sv */
`timescale 1ns/10ps

module tb_chol;
    import chol_fixed_pkg::*;

    localparam int CLK_HALF        = 4;     // 8 ns period
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 2000;
    localparam int MAX_WAIT        = 2000;  // Per handshake
    localparam int DIAG_BOOST      = 5;     // A = M*M' + 5*I

    logic clk;
    logic rst;
    tri_t a;
    logic a_valid;
    logic a_ready;
    tri_t l;
    logic l_valid;

    integer seed;
    fx_t    m_mat [MAT_N][MAT_N];           // Source of dense SPD matrices

    `include "tb_chol_model.svh"

    chol_top u_chol_top (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .l       (l),
        .l_valid (l_valid)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Checking
    // --------------------
    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_tri(input string name, input tri_t got, input tri_t exp);
        int n;
        for (n = 0; n < TRI_LEN; n++) begin
            if (got[n] !== exp[n]) begin
                $display("ERR %s[%0d] got %h expected %h", name, n, got[n], exp[n]);
                stop_run();
            end
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) @(posedge clk);
        $display("Watchdog expired before all tests completed");
        stop_run();
    end

    // Stimulus helpers
    // --------------------
    task automatic send_matrix(input tri_t m);
        int waited;
        waited = 0;
        @(posedge clk);
        a       <= m;
        a_valid <= 1'b1;
        @(negedge clk);
        while (!a_ready) begin
            waited++;
            if (waited > MAX_WAIT) begin
                $display("DUT never raised a_ready for a new matrix");
                stop_run();
            end
            @(negedge clk);
        end
        @(posedge clk);                     // Transfer edge
        a_valid <= 1'b0;
    endtask

    task automatic wait_result();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!l_valid) begin
            waited++;
            if (waited > MAX_WAIT) begin
                $display("DUT never pulsed l_valid after accepting a matrix");
                stop_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic run_and_check(input tri_t m, input tri_t exp);
        send_matrix(m);
        wait_result();
        check_tri("l", l, exp);
        @(negedge clk);
        check_bit("l_valid", l_valid, 1'b0);   // Single-cycle strobe
        check_bit("a_ready", a_ready, 1'b1);
    endtask

    task automatic fill_m_pattern(input int salt);
        int r;
        int c;
        for (r = 0; r < MAT_N; r++) begin
            for (c = 0; c < MAT_N; c++) begin
                m_mat[r][c] = fx_t'((((r * 3 + c * 5 + salt) % 7) - 3) * 24576); // Steps of 0.375
            end
        end
    endtask

    task automatic fill_m_random();
        int r;
        int c;
        for (r = 0; r < MAT_N; r++) begin
            for (c = 0; c < MAT_N; c++) begin
                m_mat[r][c] = fx_t'($random(seed) % 262144);   // Within (-4, 4)
            end
        end
    endtask

    function automatic tri_t spd_from_m();
        tri_t   m;
        longint sum;
        int     i;
        int     j;
        int     k;
        m = '0;
        for (i = 0; i < MAT_N; i++) begin
            for (j = 0; j <= i; j++) begin
                sum = 0;
                for (k = 0; k < MAT_N; k++) begin
                    sum += longint'(m_mat[i][k]) * longint'(m_mat[j][k]);
                end
                m[tri_pos(i, j)] = fx_t'(sum >>> FRAC_BITS);
                if (i == j) begin
                    m[tri_pos(i, j)] = m[tri_pos(i, j)] + fx_t'(DIAG_BOOST <<< FRAC_BITS);
                end
            end
        end
        return m;
    endfunction

    // Directed tests
    // --------------------
    task automatic test_reset_state();
        @(negedge clk);
        check_bit("a_ready", a_ready, 1'b1);
        check_bit("l_valid", l_valid, 1'b0);
        check_tri("l", l, '0);
    endtask

    task automatic test_identity();
        tri_t m;
        int   n;
        m = '0;
        for (n = 0; n < MAT_N; n++) begin
            m[tri_pos(n, n)] = fx_t'(1 <<< FRAC_BITS);
        end
        run_and_check(m, m);                // L of I is I
    endtask

    task automatic test_diagonal();
        int   in_val [MAT_N];
        int   root   [MAT_N];
        tri_t m;
        tri_t exp;
        int   n;
        in_val = '{4, 9, 16, 25, 1};
        root   = '{2, 3, 4, 5, 1};
        m      = '0;
        exp    = '0;
        for (n = 0; n < MAT_N; n++) begin
            m[tri_pos(n, n)]   = fx_t'(in_val[n] <<< FRAC_BITS);
            exp[tri_pos(n, n)] = fx_t'(root[n] <<< FRAC_BITS);
        end
        run_and_check(m, exp);
    endtask

    task automatic test_full_matrix();
        tri_t m;
        fill_m_pattern(1);
        m = spd_from_m();
        run_and_check(m, model_chol(m));
    endtask

    task automatic test_busy();
        tri_t first;
        tri_t second;
        tri_t exp;
        int   n;
        fill_m_pattern(4);
        first  = spd_from_m();
        exp    = model_chol(first);
        second = '0;
        for (n = 0; n < MAT_N; n++) begin
            second[tri_pos(n, n)] = fx_t'(1 <<< FRAC_BITS);
        end
        send_matrix(first);
        @(negedge clk);
        check_bit("a_ready", a_ready, 1'b0);
        @(posedge clk);
        a       <= second;                  // Must be ignored while busy
        a_valid <= 1'b1;
        @(posedge clk);
        a_valid <= 1'b0;
        wait_result();
        check_tri("l", l, exp);
        for (n = 0; n < 100; n++) begin
            @(negedge clk);
            check_bit("l_valid", l_valid, 1'b0);
            check_bit("a_ready", a_ready, 1'b1);
        end
        check_tri("l", l, exp);             // Held after the strobe
    endtask

    task automatic test_random();
        tri_t m;
        int   n;
        for (n = 0; n < 3; n++) begin
            fill_m_random();
            m = spd_from_m();
            run_and_check(m, model_chol(m));
        end
    endtask

    // Main sequence
    // --------------------
    initial begin
        seed    = 32'ha170de97;
        rst     = 1'b1;
        a       = '0;
        a_valid = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_identity();
        test_diagonal();
        test_full_matrix();
        test_busy();
        test_random();
        $display("test passed");
        $finish;
    end

endmodule
